// ==== list.f ====
design/cmac_ctrl_pkg.sv
design/cmac_stat_pkg.sv
design/link_bringup_fsm.sv
design/traffic_stat_accum.sv
design/error_event_counter.sv
design/cmac_link_ctrl.sv
sim/cmac_link_chk.sv
sim/cmac_link_monitor.sv
sim/tb_cmac_link_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the cmac_link_ctrl testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    --top-module tb_cmac_link_ctrl \
    --Mdir "$build_dir" -o sim_top \
    -f list.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$build_dir/sim_top" +verilator+error+limit+1000 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TB FAILED" "$log_file"; then
    exit 1
fi
exit 0

// ==== sim/tb_cmac_link_ctrl.sv ====
// testbench top with clock, reset, stimulus table, LFSR stimulus, watchdog and DUT
`timescale 1ns/10ps

module tb_cmac_link_ctrl;

    localparam int N_ROWS = 13;

    // aligned, hold cycles, expected {ctl_rx_enable, ctl_tx_enable, tx_send_fault} after hold
    localparam logic [11:0] STIM_TABLE [N_ROWS] = '{
        {1'b0, 8'd2,  3'b000},  // still locking
        {1'b0, 8'd1,  3'b101},  // third edge after reset
        {1'b0, 8'd4,  3'b101},
        {1'b1, 8'd2,  3'b101},  // alignment seen, tx not up yet
        {1'b1, 8'd1,  3'b110},
        {1'b1, 8'd10, 3'b110},
        {1'b0, 8'd2,  3'b110},  // loss not visible yet
        {1'b0, 8'd1,  3'b000},
        {1'b0, 8'd1,  3'b101},
        {1'b0, 8'd3,  3'b101},
        {1'b1, 8'd2,  3'b101},  // re-alignment
        {1'b1, 8'd1,  3'b110},
        {1'b1, 8'd20, 3'b110}
    };

    logic gt_txusrclk2    = 1'b0;
    logic usr_rx_reset_w  = 1'b1;
    logic stat_rx_aligned = 1'b0;
    logic rx_good_pkts_inc;
    cmac_stat_pkg::rx_pkts_inc_t rx_total_pkts_inc;
    cmac_stat_pkg::good_bytes_inc_t rx_good_bytes_inc;
    cmac_stat_pkg::rx_bytes_inc_t rx_total_bytes_inc;
    logic tx_good_pkts_inc;
    logic [cmac_stat_pkg::TX_PKTS_INC_W-1:0] tx_total_pkts_inc;
    cmac_stat_pkg::good_bytes_inc_t tx_good_bytes_inc;
    cmac_stat_pkg::tx_bytes_inc_t tx_total_bytes_inc;
    logic rx_aligned_err, rx_bad_preamble, rx_bad_sfd, tx_ovf, tx_unf;
    cmac_stat_pkg::lane_err_t rx_bad_code, rx_bad_fcs;
    logic ctl_rx_enable, ctl_tx_enable, tx_send_fault;
    cmac_stat_pkg::total_cnt_t rx_good_pkts, rx_total_pkts, rx_good_bytes, rx_total_bytes;
    cmac_stat_pkg::total_cnt_t tx_good_pkts, tx_total_pkts, tx_good_bytes, tx_total_bytes;
    cmac_stat_pkg::err_cnt_t align_errs, code_errs, fcs_errs, preamble_errs, sfd_errs;
    cmac_stat_pkg::err_cnt_t overflow_cnt, underflow_cnt;

    logic [2:0]  exp_ctl    = '0;
    logic        check_en   = 1'b0;
    logic [31:0] lfsr_state = 32'h664e_b09a;
    int          error_cnt;
    int          check_cnt;

    always #10 gt_txusrclk2 = ~gt_txusrclk2;

    cmac_link_ctrl i_dut (.*);

    bind cmac_link_ctrl cmac_link_chk u_chk (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .ctl_rx_enable  (ctl_rx_enable),
        .ctl_tx_enable  (ctl_tx_enable),
        .tx_send_fault  (tx_send_fault)
    );

    cmac_link_monitor u_monitor (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .totals         ({tx_total_bytes, tx_good_bytes, tx_total_pkts, tx_good_pkts,
                          rx_total_bytes, rx_good_bytes, rx_total_pkts, rx_good_pkts}),
        .incs           ({32'(tx_total_bytes_inc), 32'(tx_good_bytes_inc),
                          32'(tx_total_pkts_inc), 32'(tx_good_pkts_inc),
                          32'(rx_total_bytes_inc), 32'(rx_good_bytes_inc),
                          32'(rx_total_pkts_inc), 32'(rx_good_pkts_inc)}),
        .errs           ({underflow_cnt, overflow_cnt, sfd_errs, preamble_errs, fcs_errs,
                          code_errs, align_errs}),
        .err_groups     ({3'(tx_unf), 3'(tx_ovf), 3'(rx_bad_sfd), 3'(rx_bad_preamble),
                          rx_bad_fcs, rx_bad_code, 3'(rx_aligned_err)}),
        .ctl            ({ctl_rx_enable, ctl_tx_enable, tx_send_fault}),
        .exp_ctl        (exp_ctl),
        .check_en       (check_en),
        .error_cnt      (error_cnt),
        .check_cnt      (check_cnt)
    );

    // Fibonacci form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    task automatic apply_random_stats();
        logic [63:0] bits;
        take_bits(58, bits);
        {rx_good_pkts_inc, rx_total_pkts_inc, rx_good_bytes_inc, rx_total_bytes_inc,
         tx_good_pkts_inc, tx_total_pkts_inc, tx_good_bytes_inc, tx_total_bytes_inc,
         rx_aligned_err, rx_bad_code, rx_bad_fcs, rx_bad_preamble, rx_bad_sfd,
         tx_ovf, tx_unf} = bits[57:0];
    endtask

    function automatic int watchdog_ns();
        int cycles = 50; // reset and margin
        for (int r = 0; r < N_ROWS; r++) begin
            cycles += int'(STIM_TABLE[r][10:3]);
        end
        return cycles * 20 * 2;
    endfunction

    initial begin
        logic [11:0] row;
        repeat (4) begin
            apply_random_stats(); // counts must stay at zero under reset
            @(negedge gt_txusrclk2);
        end
        usr_rx_reset_w = 1'b0;
        for (int r = 0; r < N_ROWS; r++) begin
            row = STIM_TABLE[r];
            stat_rx_aligned = row[11];
            for (int c = 0; c < int'(row[10:3]); c++) begin
                apply_random_stats();
                @(negedge gt_txusrclk2);
                check_en = 1'b0;
            end
            exp_ctl  = row[2:0]; // compared at the next rising edge
            check_en = 1'b1;
        end
        @(negedge gt_txusrclk2);
        check_en = 1'b0;
        $display("checks %0d, errors %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns());
        $display("timeout, the run did not finish within %0d ns", watchdog_ns());
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== sim/cmac_link_monitor.sv ====
// reference model of traffic totals and error counts and comparison of every DUT output
`timescale 1ns/10ps

module cmac_link_monitor (
    input  logic                                   gt_txusrclk2,
    input  logic                                   usr_rx_reset_w,
    input  logic [7:0][cmac_stat_pkg::TOTAL_W-1:0] totals,     // dut totals in tot_name order
    input  logic [7:0][cmac_stat_pkg::TOTAL_W-1:0] incs,       // matching increments
    input  logic [6:0][cmac_stat_pkg::ERR_W-1:0]   errs,
    input  logic [6:0][2:0]                        err_groups, // flag groups in errs order
    input  logic [2:0]                             ctl,        // {rx enable, tx enable, fault}
    input  logic [2:0]                             exp_ctl,
    input  logic                                   check_en,   // exp_ctl valid at this edge
    output int                                     error_cnt,
    output int                                     check_cnt
);

    string tot_name [8] = '{"rx_good_pkts", "rx_total_pkts", "rx_good_bytes", "rx_total_bytes",
                            "tx_good_pkts", "tx_total_pkts", "tx_good_bytes", "tx_total_bytes"};
    string err_name [7] = '{"align_errs", "code_errs", "fcs_errs", "preamble_errs",
                            "sfd_errs", "overflow_cnt", "underflow_cnt"};
    string ctl_name [3] = '{"tx_send_fault", "ctl_tx_enable", "ctl_rx_enable"};

    cmac_stat_pkg::total_cnt_t tot_model [8];
    cmac_stat_pkg::err_cnt_t   err_model [7];
    logic model_valid = 1'b0; // set once reset has been seen
    logic rst_d       = 1'b0;
    int   errors      = 0;
    int   checks      = 0;

    assign error_cnt = errors;
    assign check_cnt = checks;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // outputs read here still hold what the previous edge produced
    always @(posedge gt_txusrclk2) begin
        for (int i = 0; i < 8 && model_valid; i++) begin
            compare(tot_name[i], totals[i], tot_model[i]);
        end
        for (int i = 0; i < 7 && model_valid; i++) begin
            compare(err_name[i], 32'(errs[i]), 32'(err_model[i]));
        end
        for (int i = 0; i < 3; i++) begin
            if (rst_d) begin
                compare(ctl_name[i], 32'(ctl[i]), 32'd0);
            end
            if (check_en) begin
                compare(ctl_name[i], 32'(ctl[i]), 32'(exp_ctl[i]));
            end
        end
        if (ctl[1] && (ctl[0] || !ctl[2])) begin
            errors++;
            $display("error at %0t: tx enabled with send fault high or rx disabled", $time);
        end
        for (int i = 0; i < 8; i++) begin
            tot_model[i] = usr_rx_reset_w ? '0 : tot_model[i] + incs[i];
        end
        for (int i = 0; i < 7; i++) begin
            // a group counts once per cycle however many lanes flag
            err_model[i] = usr_rx_reset_w ? '0 :
                           err_model[i] + cmac_stat_pkg::err_cnt_t'(|err_groups[i]);
        end
        model_valid = model_valid || usr_rx_reset_w;
        rst_d       = usr_rx_reset_w;
    end

endmodule

// ==== sim/cmac_link_chk.sv ====
// bound assertions on the MAC control levels
`timescale 1ns/10ps

module cmac_link_chk (
    input logic gt_txusrclk2,
    input logic usr_rx_reset_w,
    input logic ctl_rx_enable,
    input logic ctl_tx_enable,
    input logic tx_send_fault
);

    tx_fault_excl: assert property (@(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
        !(ctl_tx_enable && tx_send_fault))
        else $error("ctl_tx_enable and tx_send_fault are high in the same cycle");

    tx_needs_rx: assert property (@(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
        ctl_tx_enable |-> ctl_rx_enable)
        else $error("ctl_tx_enable is high while ctl_rx_enable is low");

    // controls must be cleared one edge after reset is seen
    reset_clears: assert property (@(posedge gt_txusrclk2)
        usr_rx_reset_w |=> !(ctl_rx_enable || ctl_tx_enable || tx_send_fault))
        else $error("a control level is still high after reset");

endmodule

// ==== design/cmac_link_ctrl.sv ====
// top level with the bring-up state machine, rx/tx traffic totals and error counters
`timescale 1ns/10ps

module cmac_link_ctrl (
    input  logic                                gt_txusrclk2,
    input  logic                                usr_rx_reset_w,
    input  logic                                stat_rx_aligned,
    // rx per-cycle statistics
    input  logic                                rx_good_pkts_inc,
    input  cmac_stat_pkg::rx_pkts_inc_t         rx_total_pkts_inc,
    input  cmac_stat_pkg::good_bytes_inc_t      rx_good_bytes_inc,
    input  cmac_stat_pkg::rx_bytes_inc_t        rx_total_bytes_inc,
    // tx per-cycle statistics
    input  logic                                tx_good_pkts_inc,
    input  logic [cmac_stat_pkg::TX_PKTS_INC_W-1:0] tx_total_pkts_inc,
    input  cmac_stat_pkg::good_bytes_inc_t      tx_good_bytes_inc,
    input  cmac_stat_pkg::tx_bytes_inc_t        tx_total_bytes_inc,
    // error flags
    input  logic                                rx_aligned_err,
    input  cmac_stat_pkg::lane_err_t            rx_bad_code,
    input  cmac_stat_pkg::lane_err_t            rx_bad_fcs,
    input  logic                                rx_bad_preamble,
    input  logic                                rx_bad_sfd,
    input  logic                                tx_ovf,
    input  logic                                tx_unf,
    // MAC control levels
    output logic                                ctl_rx_enable,
    output logic                                ctl_tx_enable,
    output logic                                tx_send_fault,
    // traffic totals
    output cmac_stat_pkg::total_cnt_t           rx_good_pkts,
    output cmac_stat_pkg::total_cnt_t           rx_total_pkts,
    output cmac_stat_pkg::total_cnt_t           rx_good_bytes,
    output cmac_stat_pkg::total_cnt_t           rx_total_bytes,
    output cmac_stat_pkg::total_cnt_t           tx_good_pkts,
    output cmac_stat_pkg::total_cnt_t           tx_total_pkts,
    output cmac_stat_pkg::total_cnt_t           tx_good_bytes,
    output cmac_stat_pkg::total_cnt_t           tx_total_bytes,
    // error event counts
    output cmac_stat_pkg::err_cnt_t             align_errs,
    output cmac_stat_pkg::err_cnt_t             code_errs,
    output cmac_stat_pkg::err_cnt_t             fcs_errs,
    output cmac_stat_pkg::err_cnt_t             preamble_errs,
    output cmac_stat_pkg::err_cnt_t             sfd_errs,
    output cmac_stat_pkg::err_cnt_t             overflow_cnt,
    output cmac_stat_pkg::err_cnt_t             underflow_cnt
);

    link_bringup_fsm u_link_fsm (
        .gt_txusrclk2    (gt_txusrclk2),
        .usr_rx_reset_w  (usr_rx_reset_w),
        .stat_rx_aligned (stat_rx_aligned),
        .ctl_rx_enable   (ctl_rx_enable),
        .ctl_tx_enable   (ctl_tx_enable),
        .tx_send_fault   (tx_send_fault)
    );

    traffic_stat_accum #(
        .COUNT_W    (cmac_stat_pkg::TOTAL_W),
        .PKT_INC_W  (cmac_stat_pkg::RX_PKTS_INC_W),
        .BYTE_INC_W (cmac_stat_pkg::RX_BYTES_INC_W)
    ) u_rx_stat (
        .gt_txusrclk2    (gt_txusrclk2),
        .usr_rx_reset_w  (usr_rx_reset_w),
        .good_pkts_inc   (rx_good_pkts_inc),
        .total_pkts_inc  (rx_total_pkts_inc),
        .good_bytes_inc  (rx_good_bytes_inc),
        .total_bytes_inc (rx_total_bytes_inc),
        .good_pkts       (rx_good_pkts),
        .total_pkts      (rx_total_pkts),
        .good_bytes      (rx_good_bytes),
        .total_bytes     (rx_total_bytes)
    );

    traffic_stat_accum #(
        .COUNT_W    (cmac_stat_pkg::TOTAL_W),
        .PKT_INC_W  (cmac_stat_pkg::TX_PKTS_INC_W),
        .BYTE_INC_W (cmac_stat_pkg::TX_BYTES_INC_W)
    ) u_tx_stat (
        .gt_txusrclk2    (gt_txusrclk2),
        .usr_rx_reset_w  (usr_rx_reset_w),
        .good_pkts_inc   (tx_good_pkts_inc),
        .total_pkts_inc  (tx_total_pkts_inc),
        .good_bytes_inc  (tx_good_bytes_inc),
        .total_bytes_inc (tx_total_bytes_inc),
        .good_pkts       (tx_good_pkts),
        .total_pkts      (tx_total_pkts),
        .good_bytes      (tx_good_bytes),
        .total_bytes     (tx_total_bytes)
    );

    error_event_counter #(
        .COUNT_W (cmac_stat_pkg::ERR_W)
    ) u_err_cnt (
        .gt_txusrclk2    (gt_txusrclk2),
        .usr_rx_reset_w  (usr_rx_reset_w),
        .rx_aligned_err  (rx_aligned_err),
        .rx_bad_code     (rx_bad_code),
        .rx_bad_fcs      (rx_bad_fcs),
        .rx_bad_preamble (rx_bad_preamble),
        .rx_bad_sfd      (rx_bad_sfd),
        .tx_ovf          (tx_ovf),
        .tx_unf          (tx_unf),
        .align_errs      (align_errs),
        .code_errs       (code_errs),
        .fcs_errs        (fcs_errs),
        .preamble_errs   (preamble_errs),
        .sfd_errs        (sfd_errs),
        .overflow_cnt    (overflow_cnt),
        .underflow_cnt   (underflow_cnt)
    );

endmodule

// ==== design/error_event_counter.sv ====
// per-group error and tx FIFO fault cycle counters
`timescale 1ns/10ps

module error_event_counter #(
    parameter int COUNT_W = 16
) (
    input  logic                     gt_txusrclk2,
    input  logic                     usr_rx_reset_w,
    input  logic                     rx_aligned_err,
    input  cmac_stat_pkg::lane_err_t rx_bad_code,
    input  cmac_stat_pkg::lane_err_t rx_bad_fcs,
    input  logic                     rx_bad_preamble,
    input  logic                     rx_bad_sfd,
    input  logic                     tx_ovf,
    input  logic                     tx_unf,
    output logic [COUNT_W-1:0]       align_errs,
    output logic [COUNT_W-1:0]       code_errs,
    output logic [COUNT_W-1:0]       fcs_errs,
    output logic [COUNT_W-1:0]       preamble_errs,
    output logic [COUNT_W-1:0]       sfd_errs,
    output logic [COUNT_W-1:0]       overflow_cnt,
    output logic [COUNT_W-1:0]       underflow_cnt
);

    localparam int N_EVT = 7;

    logic [N_EVT-1:0]   evt;         // one bit per flag group
    logic [COUNT_W-1:0] cnt [N_EVT];

    // lane groups reduce to one event, several lanes in a cycle count once
    assign evt = {tx_unf, tx_ovf, rx_bad_sfd, rx_bad_preamble,
                  |rx_bad_fcs, |rx_bad_code, rx_aligned_err};

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            for (int i = 0; i < N_EVT; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N_EVT; i++) begin
                if (evt[i]) begin
                    cnt[i] <= cnt[i] + COUNT_W'(1); // wraps
                end
            end
        end
    end

    assign align_errs    = cnt[0];
    assign code_errs     = cnt[1];
    assign fcs_errs      = cnt[2];
    assign preamble_errs = cnt[3];
    assign sfd_errs      = cnt[4];
    assign overflow_cnt  = cnt[5];
    assign underflow_cnt = cnt[6];

endmodule

// ==== design/traffic_stat_accum.sv ====
// running packet and byte totals from per-cycle MAC statistics
`timescale 1ns/10ps

module traffic_stat_accum #(
    parameter int COUNT_W    = 32,
    parameter int PKT_INC_W  = 3,
    parameter int BYTE_INC_W = 7
) (
    input  logic                           gt_txusrclk2,
    input  logic                           usr_rx_reset_w,
    input  logic                           good_pkts_inc,
    input  logic [PKT_INC_W-1:0]           total_pkts_inc,
    input  cmac_stat_pkg::good_bytes_inc_t good_bytes_inc,
    input  logic [BYTE_INC_W-1:0]          total_bytes_inc,
    output logic [COUNT_W-1:0]             good_pkts,
    output logic [COUNT_W-1:0]             total_pkts,
    output logic [COUNT_W-1:0]             good_bytes,
    output logic [COUNT_W-1:0]             total_bytes
);

    // totals wrap at COUNT_W, increments are zero-extended
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            good_pkts   <= '0;
            total_pkts  <= '0;
            good_bytes  <= '0;
            total_bytes <= '0;
        end else begin
            good_pkts   <= good_pkts + COUNT_W'(good_pkts_inc);
            total_pkts  <= total_pkts + COUNT_W'(total_pkts_inc);
            good_bytes  <= good_bytes + COUNT_W'(good_bytes_inc);
            total_bytes <= total_bytes + COUNT_W'(total_bytes_inc);
        end
    end

endmodule

// ==== design/link_bringup_fsm.sv ====
// alignment-driven link bring-up state machine for the rx/tx control levels
`timescale 1ns/10ps

module link_bringup_fsm (
    input  logic gt_txusrclk2,
    input  logic usr_rx_reset_w,
    input  logic stat_rx_aligned,
    output logic ctl_rx_enable,
    output logic ctl_tx_enable,
    output logic tx_send_fault
);

    logic                      reset_done; // first clean edge after reset
    logic                      aligned_d;  // registered alignment status
    cmac_ctrl_pkg::link_state_t link_state;

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            link_state    <= cmac_ctrl_pkg::link_idle;
            reset_done    <= 1'b0;
            aligned_d     <= 1'b0;
            ctl_rx_enable <= 1'b0;
            ctl_tx_enable <= 1'b0;
            tx_send_fault <= 1'b0;
        end else begin
            reset_done <= 1'b1;
            aligned_d  <= stat_rx_aligned;

            case (link_state)
                cmac_ctrl_pkg::link_idle: begin
                    ctl_rx_enable <= 1'b0;
                    ctl_tx_enable <= 1'b0;
                    tx_send_fault <= 1'b0;
                    if (reset_done) begin
                        link_state <= cmac_ctrl_pkg::link_gt_locked;
                    end
                end

                cmac_ctrl_pkg::link_gt_locked: begin
                    ctl_rx_enable <= 1'b1;
                    ctl_tx_enable <= 1'b0;
                    tx_send_fault <= 1'b1; // local and remote fault to the peer
                    link_state    <= cmac_ctrl_pkg::link_wait_aligned;
                end

                cmac_ctrl_pkg::link_wait_aligned: begin
                    if (aligned_d) begin
                        link_state <= cmac_ctrl_pkg::link_up;
                    end
                end

                cmac_ctrl_pkg::link_up: begin
                    // refreshed every cycle while the link holds
                    ctl_tx_enable <= 1'b1;
                    tx_send_fault <= 1'b0;
                    if (!aligned_d) begin
                        link_state <= cmac_ctrl_pkg::link_idle; // restart bring-up
                    end
                end

                default: begin
                    link_state <= cmac_ctrl_pkg::link_idle;
                end
            endcase
        end
    end

endmodule

// ==== design/cmac_stat_pkg.sv ====
// statistics widths and vector types for the MAC counters
package cmac_stat_pkg;

    localparam int TOTAL_W = 32; // packet and byte totals
    localparam int ERR_W   = 16; // error event counts

    // per-cycle increment widths as reported by the MAC
    localparam int RX_BYTES_INC_W   = 7;
    localparam int TX_BYTES_INC_W   = 6;
    localparam int GOOD_BYTES_INC_W = 14;
    localparam int RX_PKTS_INC_W    = 3;
    localparam int TX_PKTS_INC_W    = 1; // at most one packet per cycle on tx
    localparam int LANE_ERR_W       = 3; // bad code / bad fcs flag groups

    typedef logic [TOTAL_W-1:0]          total_cnt_t;
    typedef logic [ERR_W-1:0]            err_cnt_t;

    typedef logic [RX_BYTES_INC_W-1:0]   rx_bytes_inc_t;
    typedef logic [TX_BYTES_INC_W-1:0]   tx_bytes_inc_t;
    typedef logic [GOOD_BYTES_INC_W-1:0] good_bytes_inc_t;
    typedef logic [RX_PKTS_INC_W-1:0]    rx_pkts_inc_t;

    typedef logic [LANE_ERR_W-1:0]       lane_err_t;

endpackage

// ==== design/cmac_ctrl_pkg.sv ====
// link bring-up state encoding and control-side widths
package cmac_ctrl_pkg;

    // state register width, four states fit in two bits
    localparam int LINK_STATE_W = 2;

    // bring-up sequence of the merged rx/tx state machine
    //   link_idle          controls cleared, waits for reset_done
    //   link_gt_locked     one cycle, raises rx enable and fault signalling
    //   link_wait_aligned  holds until the registered alignment is high
    //   link_up            tx enabled, fault signalling dropped
    typedef enum logic [LINK_STATE_W-1:0] {
        link_idle         = 2'd0,
        link_gt_locked    = 2'd1,
        link_wait_aligned = 2'd2,
        link_up           = 2'd3
    } link_state_t;

endpackage
